//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = ecc_mem_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /PASS: all tests/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- src.f
src/ecc_mem_pkg.sv
src/ecc_encoder.sv
src/ecc_decoder.sv
src/delay_line.sv
src/bank_array.sv
src/ecc_apb_regs.sv
src/ecc_mem_top.sv
test/ecc_mem_sva.sv
test/ecc_mem_tb.sv

//--- src/bank_array.sv
`default_nettype none

module bank_array #(
  parameter  int NUMVBNK    = 4,
  parameter  int NUMSROW    = 16,
  parameter  int NUMWRDS    = 4,
  parameter  int SRAM_DELAY = 2,
  localparam int BITVBNK    = $clog2(NUMVBNK),
  localparam int BITSROW    = $clog2(NUMSROW),
  localparam int BITWRDS    = (NUMWRDS > 1) ? $clog2(NUMWRDS) : 1
) (
  input  logic                                clk,
  input  logic                                wr_en,
  input  logic [BITVBNK-1:0]                  wr_bnk,
  input  logic [BITSROW-1:0]                  wr_row,
  input  logic [BITWRDS-1:0]                  wr_word,
  input  ecc_mem_pkg::code_t                  wr_code,
  input  logic                                rd_en,
  input  logic [BITVBNK-1:0]                  rd_bnk,
  input  logic [BITSROW-1:0]                  rd_row,
  output ecc_mem_pkg::code_t [NUMWRDS-1:0]    rd_row_data
);

  typedef ecc_mem_pkg::code_t [NUMWRDS-1:0] row_t;

  row_t mem [NUMVBNK][NUMSROW];                   // One physical row per entry
  row_t rd_pipe [SRAM_DELAY];

  ////////////////////////////////////////////////////////////
  // Write port

  // Only the addressed word changes, its neighbours keep their value
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_bnk][wr_row][wr_word] <= wr_code;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_bnk][rd_row];          // Array read register
    end
    for (int s = 1; s < SRAM_DELAY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign rd_row_data = rd_pipe[SRAM_DELAY-1];

endmodule

`default_nettype wire

//--- src/delay_line.sv
`default_nettype none

module delay_line #(
  parameter int  DEPTH     = 1,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_vld,
  input  payload_t in_data,
  output logic     out_vld,
  output payload_t out_data
);

  if (DEPTH == 0) begin : g_pass
    assign out_vld  = in_vld;
    assign out_data = in_data;
  end else begin : g_pipe
    logic [DEPTH-1:0] vld_q;
    payload_t data_q [DEPTH];

    always_ff @(posedge clk) begin
      if (rst) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= in_vld;
        for (int s = 1; s < DEPTH; s++) begin
          vld_q[s] <= vld_q[s-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      data_q[0] <= in_data;
      for (int s = 1; s < DEPTH; s++) begin
        data_q[s] <= data_q[s-1];
      end
    end

    assign out_vld  = vld_q[DEPTH-1];
    assign out_data = data_q[DEPTH-1];
  end

endmodule

`default_nettype wire

//--- src/ecc_apb_regs.sv
`default_nettype none

module ecc_apb_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  ecc_mem_pkg::apb_req_t apb_req,
  output ecc_mem_pkg::apb_rsp_t apb_rsp,
  output ecc_mem_pkg::inject_t  inject,
  input  logic                  inject_used,
  input  logic                  serr_evt,
  input  logic                  derr_evt
);

  localparam int cnt_w = 16;

  typedef struct packed {
    logic serr;
    logic derr;
  } err_evt_t;

  logic                  access;
  logic                  wr_access;
  err_evt_t              evt_in;
  err_evt_t              evt_q;
  logic                  evt_vld;
  logic [1:0]            cnt_clr;                 // Index 0 serr, index 1 derr
  logic [1:0]            cnt_inc;
  logic [1:0][cnt_w-1:0] cnt;

  assign access    = apb_req.psel && apb_req.penable;
  assign wr_access = access && apb_req.pwrite;

  ////////////////////////////////////////////////////////////
  // Injection request

  always_ff @(posedge clk) begin
    if (rst) begin
      inject <= '0;
    end else if (wr_access && apb_req.paddr == ecc_mem_pkg::reg_inject) begin
      inject <= ecc_mem_pkg::inject_t'(apb_req.pwdata[$bits(ecc_mem_pkg::inject_t)-1:0]);
    end else if (inject_used) begin
      inject.single_en <= 1'b0;                   // One write consumes it
      inject.double_en <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Error counters

  assign evt_in = '{serr: serr_evt, derr: derr_evt};

  delay_line #(
    .DEPTH     (1),
    .payload_t (err_evt_t)
  ) evt_dly_i (
    .clk      (clk),
    .rst      (rst),
    .in_vld   (serr_evt || derr_evt),
    .in_data  (evt_in),
    .out_vld  (evt_vld),
    .out_data (evt_q)
  );

  assign cnt_clr[0] = wr_access && apb_req.paddr == ecc_mem_pkg::reg_serr_cnt;
  assign cnt_clr[1] = wr_access && apb_req.paddr == ecc_mem_pkg::reg_derr_cnt;
  assign cnt_inc[0] = evt_vld && evt_q.serr;
  assign cnt_inc[1] = evt_vld && evt_q.derr;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      for (int k = 0; k < 2; k++) begin
        if (cnt_clr[k]) cnt[k] <= '0;
        else if (cnt_inc[k] && cnt[k] != '1) cnt[k] <= cnt[k] + 1'b1;  // Saturate
      end
    end
  end

  // Read mux with zero wait states
  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = 1'b0;
    apb_rsp.prdata  = '0;
    case (apb_req.paddr)
      ecc_mem_pkg::reg_inject:   apb_rsp.prdata = ecc_mem_pkg::data_w'(inject);
      ecc_mem_pkg::reg_serr_cnt: apb_rsp.prdata = ecc_mem_pkg::data_w'(cnt[0]);
      ecc_mem_pkg::reg_derr_cnt: apb_rsp.prdata = ecc_mem_pkg::data_w'(cnt[1]);
      default:                   apb_rsp.pslverr = access;
    endcase
  end

endmodule

`default_nettype wire

//--- src/ecc_decoder.sv
`default_nettype none

module ecc_decoder (
  input  ecc_mem_pkg::code_t      code,
  output ecc_mem_pkg::rd_result_t result
);

  always_comb begin
    logic [ecc_mem_pkg::ham_w-1:0] syndrome;
    logic parity_bad;
    ecc_mem_pkg::code_t fixed;
    ecc_mem_pkg::rd_result_t res;
    int j;
    for (int i = 0; i < ecc_mem_pkg::ham_w; i++) begin
      syndrome[i] = ^(code & ecc_mem_pkg::hamming_mask[i]);
    end
    parity_bad = ^code;
    fixed = code;
    res = '0;

    if (parity_bad) begin
      if (syndrome == '0) begin
        res.serr = 1'b1;                          // Overall parity bit itself flipped
      end else if (int'(syndrome) < ecc_mem_pkg::code_w) begin
        fixed = code ^ (ecc_mem_pkg::code_t'(1) << syndrome);
        res.serr = 1'b1;
      end else begin
        res.derr = 1'b1;                          // Syndrome beyond the codeword
      end
    end else if (syndrome != '0) begin
      res.derr = 1'b1;
    end

    // Gather the data bits back out
    j = 0;
    for (int p = 1; p < ecc_mem_pkg::code_w; p++) begin
      if ((p & (p - 1)) != 0) begin
        res.data[j] = fixed[p];
        j++;
      end
    end
    result = res;
  end

endmodule

`default_nettype wire

//--- src/ecc_encoder.sv
`default_nettype none

module ecc_encoder (
  input  ecc_mem_pkg::data_t data,
  output ecc_mem_pkg::code_t code
);

  always_comb begin
    ecc_mem_pkg::code_t c;
    int j;
    c = '0;
    j = 0;
    // Data fills every position that is not a power of two
    for (int p = 1; p < ecc_mem_pkg::code_w; p++) begin
      if ((p & (p - 1)) != 0) begin
        c[p] = data[j];
        j++;
      end
    end
    for (int i = 0; i < ecc_mem_pkg::ham_w; i++) begin
      c[1 << i] = ^(c & ecc_mem_pkg::hamming_mask[i]);  // Check slots still zero here
    end
    c[0] = ^c[ecc_mem_pkg::code_w-1:1];           // Overall parity
    code = c;
  end

endmodule

`default_nettype wire

//--- src/ecc_mem_pkg.sv
`default_nettype none

package ecc_mem_pkg;

  localparam int data_w     = 32;
  localparam int ecc_w      = 7;                  // Six Hamming bits plus overall parity
  localparam int ham_w      = ecc_w - 1;
  localparam int code_w     = data_w + ecc_w;
  localparam int apb_addr_w = 4;

  typedef logic [data_w-1:0] data_t;
  typedef logic [code_w-1:0] code_t;

  typedef struct packed {
    data_t data;
    logic  serr;
    logic  derr;
  } rd_result_t;

  typedef struct packed {
    logic       single_en;                        // Flip pos_a
    logic       double_en;                        // Flip pos_a and pos_b
    logic [5:0] pos_a;
    logic [5:0] pos_b;
  } inject_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    data_t                 pwdata;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  ////////////////////////////////////////////////////////////
  // Register map

  localparam logic [apb_addr_w-1:0] reg_inject   = 4'h0;
  localparam logic [apb_addr_w-1:0] reg_serr_cnt = 4'h4;
  localparam logic [apb_addr_w-1:0] reg_derr_cnt = 4'h8;

  ////////////////////////////////////////////////////////////
  // SEC-DED masks
  // Bit 0 is overall parity, positions 1..38 form the Hamming code
  // and check bit i sits at position 2**i

  localparam logic [ham_w-1:0][code_w-1:0] hamming_mask = {
    39'h7F_0000_0000,                             // Check bit 5
    39'h00_FFFF_0000,
    39'h00_FF00_FF00,
    39'h70_F0F0_F0F0,
    39'h4C_CCCC_CCCC,
    39'h2A_AAAA_AAAA                              // Check bit 0
  };

endpackage

`default_nettype wire

//--- src/ecc_mem_top.sv
`default_nettype none

module ecc_mem_top #(
  parameter  int NUMVBNK    = 4,
  parameter  int NUMVROW    = 64,
  parameter  int NUMWRDS    = 4,
  parameter  int SRAM_DELAY = 2,
  localparam int NUMSROW    = NUMVROW / NUMWRDS,
  localparam int BITVBNK    = $clog2(NUMVBNK),
  localparam int BITVROW    = $clog2(NUMVROW),
  localparam int BITSROW    = $clog2(NUMSROW),
  localparam int BITWRDS    = (NUMWRDS > 1) ? $clog2(NUMWRDS) : 1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    write,
  input  logic [BITVBNK-1:0]      wr_bnk,
  input  logic [BITVROW-1:0]      wr_adr,
  input  ecc_mem_pkg::data_t      din,
  input  logic                    read,
  input  logic [BITVBNK-1:0]      rd_bnk,
  input  logic [BITVROW-1:0]      rd_adr,
  output logic                    rd_vld,
  output ecc_mem_pkg::rd_result_t rd_out,
  input  ecc_mem_pkg::apb_req_t   apb_req,
  output ecc_mem_pkg::apb_rsp_t   apb_rsp
);

  typedef logic [BITWRDS-1:0] word_t;

  typedef struct packed {
    logic  vld;
    word_t word;
  } rd_tag_t;

  logic [BITSROW-1:0]                 wr_row;
  logic [BITSROW-1:0]                 rd_row;
  word_t                              wr_word;
  word_t                              rd_word;
  ecc_mem_pkg::code_t                 enc_code;
  ecc_mem_pkg::code_t                 flip_mask;
  ecc_mem_pkg::inject_t               inject;
  logic                               inject_used;
  ecc_mem_pkg::code_t [NUMWRDS-1:0]   rd_row_data;
  rd_tag_t                            rd_tag_q;
  logic                               tag_vld;
  word_t                              tag_word;
  ecc_mem_pkg::rd_result_t            dec_result;
  logic                               serr_evt;
  logic                               derr_evt;

  assign wr_row  = BITSROW'(wr_adr / NUMWRDS);
  assign wr_word = BITWRDS'(wr_adr % NUMWRDS);
  assign rd_row  = BITSROW'(rd_adr / NUMWRDS);
  assign rd_word = BITWRDS'(rd_adr % NUMWRDS);

  ////////////////////////////////////////////////////////////
  // Write path

  ecc_encoder enc_i (.data(din), .code(enc_code));

  always_comb begin
    flip_mask = '0;
    if (inject.single_en || inject.double_en) flip_mask ^= ecc_mem_pkg::code_t'(1) << inject.pos_a;
    if (inject.double_en) flip_mask ^= ecc_mem_pkg::code_t'(1) << inject.pos_b;
  end

  assign inject_used = write && (inject.single_en || inject.double_en);

  bank_array #(
    .NUMVBNK    (NUMVBNK),
    .NUMSROW    (NUMSROW),
    .NUMWRDS    (NUMWRDS),
    .SRAM_DELAY (SRAM_DELAY)
  ) bank_array_i (
    .clk         (clk),
    .wr_en       (write),
    .wr_bnk      (wr_bnk),
    .wr_row      (wr_row),
    .wr_word     (wr_word),
    .wr_code     (enc_code ^ flip_mask),
    .rd_en       (read),
    .rd_bnk      (rd_bnk),
    .rd_row      (rd_row),
    .rd_row_data (rd_row_data)
  );

  ////////////////////////////////////////////////////////////
  // Read path

  // Tag follows the array read register, then the remaining stages
  always_ff @(posedge clk) begin
    rd_tag_q.word <= rd_word;
    if (rst) rd_tag_q.vld <= 1'b0;
    else rd_tag_q.vld <= read;
  end

  delay_line #(
    .DEPTH     (SRAM_DELAY - 1),
    .payload_t (word_t)
  ) tag_dly_i (
    .clk      (clk),
    .rst      (rst),
    .in_vld   (rd_tag_q.vld),
    .in_data  (rd_tag_q.word),
    .out_vld  (tag_vld),
    .out_data (tag_word)
  );

  ecc_decoder dec_i (.code(rd_row_data[tag_word]), .result(dec_result));

  always_ff @(posedge clk) begin
    rd_out <= dec_result;
    if (rst) rd_vld <= 1'b0;
    else rd_vld <= tag_vld;
  end

  assign serr_evt = rd_vld && rd_out.serr;
  assign derr_evt = rd_vld && rd_out.derr;

  ecc_apb_regs regs_i (
    .clk         (clk),
    .rst         (rst),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .inject      (inject),
    .inject_used (inject_used),
    .serr_evt    (serr_evt),
    .derr_evt    (derr_evt)
  );

endmodule

`default_nettype wire

//--- test/ecc_mem_sva.sv
`default_nettype none

module ecc_mem_sva #(
  parameter  int NUMVBNK    = 4,
  parameter  int NUMVROW    = 64,
  parameter  int SRAM_DELAY = 2,
  localparam int BITVBNK    = $clog2(NUMVBNK),
  localparam int BITVROW    = $clog2(NUMVROW)
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    write,
  input logic [BITVBNK-1:0]      wr_bnk,
  input logic [BITVROW-1:0]      wr_adr,
  input logic                    read,
  input logic [BITVBNK-1:0]      rd_bnk,
  input logic [BITVROW-1:0]      rd_adr,
  input logic                    rd_vld,
  input ecc_mem_pkg::rd_result_t rd_out
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////
  // Port rules

  assert property (@(posedge clk) disable iff (rst) read && write |-> rd_bnk != wr_bnk)
    else $error("read and write both address bank %0d", rd_bnk);

  assert property (@(posedge clk) disable iff (rst)
    read |-> int'(rd_adr) < NUMVROW && int'(rd_bnk) < NUMVBNK)
    else $error("read address out of range");

  assert property (@(posedge clk) disable iff (rst)
    write |-> int'(wr_adr) < NUMVROW && int'(wr_bnk) < NUMVBNK)
    else $error("write address out of range");

  ////////////////////////////////////////////////////////////
  // Read result

  // One result per read, at fixed latency
  assert property (@(posedge clk) disable iff (rst) rd_vld == $past(read, SRAM_DELAY + 1))
    else $error("rd_vld does not follow read by %0d cycles", SRAM_DELAY + 1);

  assert property (@(posedge clk) disable iff (rst) rd_vld |-> !(rd_out.serr && rd_out.derr))
    else $error("serr and derr high together");

  assert property (@(posedge clk) disable iff (rst) rd_vld |-> !$isunknown(rd_out))
    else $error("rd_out unknown while rd_vld");

endmodule

`default_nettype wire

//--- test/ecc_mem_tb.sv
`default_nettype none

module ecc_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef ecc_mem_pkg::data_t      data_t;
  typedef ecc_mem_pkg::rd_result_t rd_result_t;
  typedef ecc_mem_pkg::inject_t    inject_t;

  localparam int NUMVBNK     = 4;
  localparam int NUMVROW     = 64;
  localparam int NUMWRDS     = 4;
  localparam int SRAM_DELAY  = 2;
  localparam int BITVBNK     = $clog2(NUMVBNK);
  localparam int BITVROW     = $clog2(NUMVROW);
  localparam int num_access  = 191;               // Memory and APB accesses over all tests
  localparam int cycle_limit = num_access * (SRAM_DELAY + 4) + 500;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  write;
  logic [BITVBNK-1:0]    wr_bnk;
  logic [BITVROW-1:0]    wr_adr;
  data_t                 din;
  logic                  read;
  logic [BITVBNK-1:0]    rd_bnk;
  logic [BITVROW-1:0]    rd_adr;
  logic                  rd_vld;
  rd_result_t            rd_out;
  ecc_mem_pkg::apb_req_t apb_req;
  ecc_mem_pkg::apb_rsp_t apb_rsp;

  data_t       model [NUMVBNK][NUMVROW];
  rd_result_t  exp_q [$];
  int          due_q [$];                         // Cycle in which each result is due
  logic [31:0] lfsr = 32'hf913_7d7c;
  int          cycles = 0;
  int          value_errs = 0;
  int          other_errs = 0;

  ecc_mem_top #(
    .NUMVBNK    (NUMVBNK),
    .NUMVROW    (NUMVROW),
    .NUMWRDS    (NUMWRDS),
    .SRAM_DELAY (SRAM_DELAY)
  ) ecc_mem_top_i (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_bnk  (wr_bnk),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_bnk  (rd_bnk),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_out  (rd_out),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  bind ecc_mem_top ecc_mem_sva #(
    .NUMVBNK    (NUMVBNK),
    .NUMVROW    (NUMVROW),
    .SRAM_DELAY (SRAM_DELAY)
  ) sva_i (
    .clk    (clk),
    .rst    (rst),
    .write  (write),
    .wr_bnk (wr_bnk),
    .wr_adr (wr_adr),
    .read   (read),
    .rd_bnk (rd_bnk),
    .rd_adr (rd_adr),
    .rd_vld (rd_vld),
    .rd_out (rd_out)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      other_errs++;
      $display("Timeout after %0d cycles with %0d reads pending", cycles, exp_q.size());
      $display("Errors: %0d wrong values, %0d other", value_errs, other_errs);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic data_t rand_word();
    data_t w;
    w = '0;
    for (int b = 0; b < ecc_mem_pkg::data_w; b++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[ecc_mem_pkg::data_w-2:0], lfsr[0]};
    end
    return w;
  endfunction

  function automatic rd_result_t make_result(input data_t d, input logic serr, input logic derr);
    return '{data: d, serr: serr, derr: derr};
  endfunction

  task automatic check_result(input string name, input rd_result_t got, input rd_result_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got data %h serr %b derr %b, expected data %h serr %b derr %b",
               $time, name, got.data, got.serr, got.derr, exp.data, exp.serr, exp.derr);
      value_errs++;
    end
  endtask

  task automatic check_reg(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h, expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  // Read results are checked mid-cycle against the queues
  always @(negedge clk) begin
    if (!rst) begin
      if (rd_vld) begin
        if (exp_q.size() == 0) begin
          $display("Read result at %0t with no read outstanding", $time);
          other_errs++;
        end else begin
          if (due_q[0] != cycles) begin
            $display("Read result at %0t came in cycle %0d, due in cycle %0d",
                     $time, cycles, due_q[0]);
            other_errs++;
          end
          check_result("rd_out", rd_out, exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end else if (due_q.size() != 0 && cycles > due_q[0]) begin
        $display("Read result due in cycle %0d never came", due_q[0]);
        other_errs++;
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    write = 1'b0;
    read  = 1'b0;
    repeat (n) step();
  endtask

  task automatic set_write(input int bnk, input int adr, input data_t data);
    write  = 1'b1;
    wr_bnk = BITVBNK'(bnk);
    wr_adr = BITVROW'(adr);
    din    = data;
    model[bnk][adr] = data;
  endtask

  task automatic set_read(input int bnk, input int adr, input rd_result_t exp);
    read   = 1'b1;
    rd_bnk = BITVBNK'(bnk);
    rd_adr = BITVROW'(adr);
    exp_q.push_back(exp);
    due_q.push_back(cycles + SRAM_DELAY + 1);
  endtask

  task automatic do_write(input int bnk, input int adr, input data_t data);
    set_write(bnk, adr, data);
    step();
    write = 1'b0;
  endtask

  task automatic queue_read(input int bnk, input int adr, input rd_result_t exp);
    set_read(bnk, adr, exp);
    step();
    read = 1'b0;
  endtask

  task automatic read_write(input int wbnk, input int wadr, input data_t data,
                            input int rbnk, input int radr);
    set_read(rbnk, radr, make_result(model[rbnk][radr], 1'b0, 1'b0));  // Prior contents
    set_write(wbnk, wadr, data);
    step();
    read  = 1'b0;
    write = 1'b0;
  endtask

  task automatic wait_reads();
    while (exp_q.size() != 0) step();
  endtask

  task automatic apb_write(input logic [3:0] addr, input data_t data);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    step();
    apb_req.penable = 1'b1;
    step();
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output data_t data, output logic err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    step();
    apb_req.penable = 1'b1;
    #2;
    if (!apb_rsp.pready) begin
      $display("APB access to offset %h at %0t not ready", addr, $time);
      other_errs++;
    end
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    step();
    apb_req = '0;
  endtask

  task automatic expect_reg(input logic [3:0] addr, input string name, input data_t exp);
    data_t got;
    logic  err;
    apb_read(addr, got, err);
    check_reg(name, got, exp);
    if (err) begin
      $display("APB read of %s at %0t raised pslverr", name, $time);
      other_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset_regs();
    data_t got;
    logic  err;
    expect_reg(ecc_mem_pkg::reg_inject, "reg_inject", '0);
    expect_reg(ecc_mem_pkg::reg_serr_cnt, "reg_serr_cnt", '0);
    expect_reg(ecc_mem_pkg::reg_derr_cnt, "reg_derr_cnt", '0);
    apb_read(4'hc, got, err);                     // Unmapped
    if (!err) begin
      $display("APB read of unmapped offset c at %0t gave no pslverr", $time);
      other_errs++;
    end
  endtask

  task automatic test_fill_read();
    for (int b = 0; b < NUMVBNK; b++)
      for (int a = 0; a < 4 * NUMWRDS; a++) do_write(b, a, rand_word());
    for (int b = 0; b < NUMVBNK; b++)
      for (int a = 0; a < 4 * NUMWRDS; a++) queue_read(b, a, make_result(model[b][a], 0, 0));
    wait_reads();
  endtask

  task automatic test_word_write();
    do_write(2, 5, rand_word());                  // Word 1 of row 1
    for (int a = 4; a < 8; a++) queue_read(2, a, make_result(model[2][a], 0, 0));
    wait_reads();
  endtask

  task automatic test_read_during_write();
    // Each read hits the word written one cycle earlier
    for (int i = 0; i < 8; i++) begin
      read_write(i % NUMVBNK, i, rand_word(), (i + 3) % NUMVBNK, (i == 0) ? 15 : i - 1);
    end
    for (int i = 0; i < 8; i++) begin
      queue_read(i % NUMVBNK, i, make_result(model[i % NUMVBNK][i], 0, 0));
    end
    wait_reads();
  endtask

  task automatic test_single_inject();
    int      single_pos [5];
    inject_t inj;
    data_t   d;
    single_pos = '{0, 1, 6, 17, 38};              // Parity bit, check bit, data bits
    foreach (single_pos[k]) begin
      d = rand_word();
      inj = '{single_en: 1'b1, double_en: 1'b0, pos_a: 6'(single_pos[k]), pos_b: 6'd0};
      apb_write(ecc_mem_pkg::reg_inject, data_t'(inj));
      do_write(1, 9, d);
      queue_read(1, 9, make_result(d, 1'b1, 1'b0));
      wait_reads();
    end
    idle(2);
    expect_reg(ecc_mem_pkg::reg_serr_cnt, "reg_serr_cnt", 5);
    do_write(1, 9, rand_word());                  // Request already consumed
    queue_read(1, 9, make_result(model[1][9], 1'b0, 1'b0));
    wait_reads();
  endtask

  task automatic test_double_inject();
    inject_t inj;
    data_t   d;
    for (int k = 0; k < 2; k++) begin
      d = rand_word();
      // Both flips on check bits, so the data bits stay as written
      inj = '{single_en: 1'b0, double_en: 1'b1, pos_a: (k == 0) ? 6'd1 : 6'd8,
              pos_b: (k == 0) ? 6'd4 : 6'd32};
      apb_write(ecc_mem_pkg::reg_inject, data_t'(inj));
      do_write(3, 12, d);
      queue_read(3, 12, make_result(d, 1'b0, 1'b1));
      wait_reads();
    end
    idle(2);
    expect_reg(ecc_mem_pkg::reg_derr_cnt, "reg_derr_cnt", 2);
    expect_reg(ecc_mem_pkg::reg_serr_cnt, "reg_serr_cnt", 5);
    apb_write(ecc_mem_pkg::reg_serr_cnt, '0);
    apb_write(ecc_mem_pkg::reg_derr_cnt, '0);
    expect_reg(ecc_mem_pkg::reg_serr_cnt, "reg_serr_cnt", '0);
    expect_reg(ecc_mem_pkg::reg_derr_cnt, "reg_derr_cnt", '0);
  endtask

  initial begin
    rst     = 1'b1;
    write   = 1'b0;
    wr_bnk  = '0;
    wr_adr  = '0;
    din     = '0;
    read    = 1'b0;
    rd_bnk  = '0;
    rd_adr  = '0;
    apb_req = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_regs();
    test_fill_read();
    test_word_write();
    test_read_during_write();
    test_single_inject();
    test_double_inject();
    idle(4);

    $display("Errors: %0d wrong values, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
